//--- src/vga_timing_pkg.sv
`default_nettype none

package vga_timing_pkg;

    // ================================================
    // Frame size for 640x480 at one pixel per clock
    // ================================================
    localparam int H_TOTAL = 800;           // Cycles per line
    localparam int V_TOTAL = 525;           // Lines per frame

    // Sync pulse windows, both active low
    localparam int H_SYNC_FIRST = 7;        // First count with hsync low
    localparam int H_SYNC_LAST  = 102;      // Last count with hsync low
    localparam int V_SYNC_FIRST = 11;
    localparam int V_SYNC_LAST  = 12;

    // Picture is active at or after both of these
    localparam int H_BLANK_END = 160;
    localparam int V_BLANK_END = 45;

    // Window in which the upstream source is asked for a pixel
    localparam int REQ_H_FIRST = 161;
    localparam int REQ_H_LAST  = 799;
    localparam int REQ_V_FIRST = 44;
    localparam int REQ_V_LAST  = 523;

    // ================================================
    // Raster types
    // ================================================
    typedef logic [10:0] hcount_t;          // Horizontal count 0..799
    typedef logic [9:0]  vcount_t;          // Line count 0..524

    // Current raster position
    typedef struct packed {
        hcount_t h;
        vcount_t v;
    } raster_pos_t;

    // Sync and blank, decoded from the position
    typedef struct packed {
        logic hsync_n;                      // Low inside the horizontal sync window
        logic vsync_n;                      // Low inside the vertical sync window
        logic active;                       // High outside blanking
    } vga_sync_t;

endpackage

`default_nettype wire

//--- src/pong_pkg.sv
`default_nettype none

package pong_pkg;

    import vga_timing_pkg::*;

    // ================================================
    // Pixel and score types
    // ================================================
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } color_t;

    typedef logic [3:0] score_t;            // 0..10

    localparam score_t SCORE_MAX = 4'd10;   // Score stops here and the digit goes blank

    localparam color_t OVERLAY_COLOR = '{r: 8'hFF, g: 8'hFF, b: 8'hFF};  // White

    // ================================================
    // Ball
    // ================================================
    localparam int BALL_SIZE = 10;          // Square side in pixels

    localparam hcount_t BALL_X0 = 11'd461;  // Start column
    localparam vcount_t BALL_Y0 = 10'd240;  // Start line

    // Playfield edges
    localparam int BALL_X_MIN  = 170;       // Left edge
    localparam int BALL_X_EDGE = 789;       // Right edge when x + BALL_SIZE reaches it
    localparam int BALL_Y_MIN  = 50;        // Top edge
    localparam int BALL_Y_EDGE = 525;       // Bottom edge when y + BALL_SIZE reaches it

    typedef struct packed {
        hcount_t x;                         // Left column of the ball
        vcount_t y;                         // Top line of the ball
        logic    dir_right;                 // 1 moves right, 0 moves left
        logic    dir_down;                  // 1 moves down, 0 moves up
    } ball_state_t;

    typedef struct packed {
        score_t left;
        score_t right;
    } score_pair_t;

    // ================================================
    // Fixed picture elements
    // ================================================
    localparam int PADDLE_L_X = 195;
    localparam int PADDLE_R_X = 744;
    localparam int PADDLE_Y   = 244;        // Both paddles share the same lines
    localparam int PADDLE_W   = 20;
    localparam int PADDLE_H   = 80;

    localparam int MID_LINE_H = 465;        // Column of the dashed middle line

    // Score digit cells
    localparam int DIGIT_TOP = 169;         // Top bar line
    localparam int DIGIT_MID = 184;         // Middle bar line, splits upper and lower posts
    localparam int DIGIT_BOT = 199;         // Bottom bar line
    localparam int DIGIT_W   = 20;          // Bar length, right post sits at CELL_X + DIGIT_W
    localparam int DIGIT_L_X = 364;
    localparam int DIGIT_R_X = 534;

endpackage

`default_nettype wire

//--- src/vga_raster_timer.sv
`default_nettype none

module vga_raster_timer (
    input  wire                         iCLK,
    input  wire                         iRST_N,
    output vga_timing_pkg::raster_pos_t pos,        // Registered raster position
    output vga_timing_pkg::vga_sync_t   sync,       // Sync and blank decode
    output logic                        request     // Ask the source for a pixel
);

    import vga_timing_pkg::*;

    raster_pos_t pos_q;
    logic        h_wrap;                            // Last count of the line
    logic        v_wrap;                            // Last line of the frame
    logic        in_hsync;
    logic        in_vsync;
    logic        req_h;
    logic        req_v;

    // ================================================
    // Counters
    // ================================================
    assign h_wrap = (pos_q.h == hcount_t'(H_TOTAL - 1));
    assign v_wrap = (pos_q.v == vcount_t'(V_TOTAL - 1));

    always_ff @(posedge iCLK or negedge iRST_N) begin
        if (!iRST_N) begin
            pos_q <= '0;
        end else begin
            // h runs every cycle
            if (h_wrap) begin
                pos_q.h <= '0;
            end else begin
                pos_q.h <= pos_q.h + 1'b1;
            end

            // v steps once per line, on the h wrap
            if (h_wrap) begin
                if (v_wrap) begin
                    pos_q.v <= '0;
                end else begin
                    pos_q.v <= pos_q.v + 1'b1;
                end
            end
        end
    end

    assign pos = pos_q;

    // ================================================
    // Decode
    // ================================================
    // Sync windows, inclusive at both ends
    assign in_hsync = (pos_q.h >= H_SYNC_FIRST) && (pos_q.h <= H_SYNC_LAST);
    assign in_vsync = (pos_q.v >= V_SYNC_FIRST) && (pos_q.v <= V_SYNC_LAST);

    // Request window
    assign req_h = (pos_q.h >= REQ_H_FIRST) && (pos_q.h <= REQ_H_LAST);
    assign req_v = (pos_q.v >= REQ_V_FIRST) && (pos_q.v <= REQ_V_LAST);

    always_comb begin
        sync.hsync_n = !in_hsync;
        sync.vsync_n = !in_vsync;
        // Visible once both back porches are over
        sync.active  = (pos_q.h >= H_BLANK_END) && (pos_q.v >= V_BLANK_END);
    end

    // Source sees pos in the same cycle
    assign request = req_h && req_v;

endmodule

`default_nettype wire

//--- src/pong_ball_engine.sv
`default_nettype none

module pong_ball_engine #(
    parameter int unsigned START_DELAY_CYCLES = 250_000_000,   // Idle time before play
    parameter int unsigned BALL_STEP_CYCLES   = 131_072         // Cycles per ball step
) (
    input  wire                   iCLK,
    input  wire                   iRST_N,
    output pong_pkg::ball_state_t ball,
    output pong_pkg::score_pair_t scores
);

    import pong_pkg::*;

    localparam int DLY_W  = $clog2(START_DELAY_CYCLES + 1);
    localparam int STEP_W = (BALL_STEP_CYCLES > 1) ? $clog2(BALL_STEP_CYCLES) : 1;

    logic [DLY_W-1:0]  delay_cnt;
    logic              delay_done;                  // Start delay has run out
    logic [STEP_W-1:0] step_cnt;
    logic              step;                        // One-cycle move strobe
    logic              at_right;
    logic              at_left;
    logic              at_bottom;
    logic              at_top;
    ball_state_t       ball_q;
    score_pair_t       scores_q;

    // ================================================
    // Start delay and step tick
    // ================================================
    always_ff @(posedge iCLK or negedge iRST_N) begin
        if (!iRST_N) begin
            delay_cnt  <= '0;
            delay_done <= 1'b0;
            step_cnt   <= '0;
        end else if (!delay_done) begin
            // Runs once, START_DELAY_CYCLES + 1 cycles in all
            if (delay_cnt == DLY_W'(START_DELAY_CYCLES)) begin
                delay_done <= 1'b1;
            end else begin
                delay_cnt <= delay_cnt + 1'b1;
            end
        end else begin
            if (step_cnt == STEP_W'(BALL_STEP_CYCLES - 1)) begin
                step_cnt <= '0;
            end else begin
                step_cnt <= step_cnt + 1'b1;
            end
        end
    end

    // First step lands on the first cycle after the delay
    assign step = delay_done && (step_cnt == '0);

    // Edge tests on the current position
    assign at_right  = (ball_q.x + BALL_SIZE >= BALL_X_EDGE);
    assign at_left   = (ball_q.x <= BALL_X_MIN);
    assign at_bottom = (ball_q.y + BALL_SIZE >= BALL_Y_EDGE);
    assign at_top    = (ball_q.y <= BALL_Y_MIN);

    // ================================================
    // Motion, bounces and scoring
    // ================================================
    always_ff @(posedge iCLK or negedge iRST_N) begin
        if (!iRST_N) begin
            ball_q   <= '{x: BALL_X0, y: BALL_Y0, dir_right: 1'b1, dir_down: 1'b1};
            scores_q <= '0;
        end else if (step) begin
            // Horizontal axis, a bounce here is a point
            if (ball_q.dir_right) begin
                if (at_right) begin
                    ball_q.dir_right <= 1'b0;           // Reverse without moving
                    if (scores_q.left < SCORE_MAX) begin
                        scores_q.left <= scores_q.left + 1'b1;
                    end
                end else begin
                    ball_q.x <= ball_q.x + 1'b1;
                end
            end else begin
                if (at_left) begin
                    ball_q.dir_right <= 1'b1;
                    if (scores_q.right < SCORE_MAX) begin
                        scores_q.right <= scores_q.right + 1'b1;
                    end
                end else begin
                    ball_q.x <= ball_q.x - 1'b1;
                end
            end

            // Vertical axis just bounces
            if (ball_q.dir_down) begin
                if (at_bottom) ball_q.dir_down <= 1'b0;
                else           ball_q.y <= ball_q.y + 1'b1;
            end else begin
                if (at_top) ball_q.dir_down <= 1'b1;
                else        ball_q.y <= ball_q.y - 1'b1;
            end
        end
    end

    assign ball   = ball_q;
    assign scores = scores_q;

endmodule

`default_nettype wire

//--- src/pong_score_glyph.sv
`default_nettype none

module pong_score_glyph #(
    parameter int CELL_X = pong_pkg::DIGIT_L_X      // Left column of the digit cell
) (
    input  wire vga_timing_pkg::raster_pos_t pos,
    input  wire pong_pkg::score_t            digit,
    output logic                             lit      // Pixel belongs to a stroke
);

    import pong_pkg::*;

    // Stroke enables for one digit
    typedef struct packed {
        logic bar_top;
        logic bar_mid;
        logic bar_bot;
        logic left_up;                              // Left post, upper half
        logic left_lo;                              // Left post, lower half
        logic right_up;
        logic right_lo;
    } strokes_t;

    strokes_t seg;
    logic     in_bar_cols;
    logic     on_left_col;
    logic     on_right_col;
    logic     in_upper;
    logic     in_lower;
    logic     bar_hit;
    logic     post_hit;

    // Digit to strokes, bits {top mid bot lu ll ru rl}
    always_comb begin
        case (digit)
            4'd0:    seg = 7'b101_1111;
            4'd1:    seg = 7'b000_0011;             // Right post only
            4'd2:    seg = 7'b111_0110;
            4'd3:    seg = 7'b111_0011;
            4'd4:    seg = 7'b010_1011;
            4'd5:    seg = 7'b111_1001;
            4'd6:    seg = 7'b111_1101;
            4'd7:    seg = 7'b100_0011;
            4'd8:    seg = 7'b111_1111;
            4'd9:    seg = 7'b111_1011;
            default: seg = '0;                      // 10 and up stay dark
        endcase
    end

    // Cell geometry
    assign in_bar_cols  = (pos.h >= CELL_X) && (pos.h < CELL_X + DIGIT_W);
    assign on_left_col  = (pos.h == CELL_X);
    assign on_right_col = (pos.h == CELL_X + DIGIT_W);
    assign in_upper     = (pos.v >= DIGIT_TOP) && (pos.v < DIGIT_MID);
    assign in_lower     = (pos.v >= DIGIT_MID) && (pos.v < DIGIT_BOT);

    assign bar_hit = in_bar_cols && ((seg.bar_top && pos.v == DIGIT_TOP) ||
                                     (seg.bar_mid && pos.v == DIGIT_MID) ||
                                     (seg.bar_bot && pos.v == DIGIT_BOT));

    assign post_hit = (on_left_col  && ((seg.left_up  && in_upper) ||
                                        (seg.left_lo  && in_lower))) ||
                      (on_right_col && ((seg.right_up && in_upper) ||
                                        (seg.right_lo && in_lower)));

    assign lit = bar_hit || post_hit;

endmodule

`default_nettype wire

//--- src/pong_pixel_mixer.sv
`default_nettype none

module pong_pixel_mixer (
    input  wire vga_timing_pkg::raster_pos_t pos,
    input  wire vga_timing_pkg::vga_sync_t   sync,
    input  wire pong_pkg::ball_state_t       ball,
    input  wire pong_pkg::score_pair_t       scores,
    input  wire pong_pkg::color_t            pixel_in,   // Colour from the source
    output pong_pkg::color_t                 pixel_out
);

    import pong_pkg::*;

    logic   paddle_l_hit;
    logic   paddle_r_hit;
    logic   ball_hit;
    logic   digit_l_lit;
    logic   digit_r_lit;
    logic   overlay_hit;
    logic   mid_line_hit;
    color_t dimmed;

    // ================================================
    // Hit tests
    // ================================================
    assign paddle_l_hit = (pos.h >= PADDLE_L_X) && (pos.h < PADDLE_L_X + PADDLE_W) &&
                          (pos.v >= PADDLE_Y)   && (pos.v < PADDLE_Y + PADDLE_H);
    assign paddle_r_hit = (pos.h >= PADDLE_R_X) && (pos.h < PADDLE_R_X + PADDLE_W) &&
                          (pos.v >= PADDLE_Y)   && (pos.v < PADDLE_Y + PADDLE_H);

    // Ball square from its top left corner
    assign ball_hit = (pos.h >= ball.x) && (pos.h < ball.x + BALL_SIZE) &&
                      (pos.v >= ball.y) && (pos.v < ball.y + BALL_SIZE);

    pong_score_glyph #(.CELL_X(DIGIT_L_X)) u_digit_l (
        .pos   (pos),
        .digit (scores.left),
        .lit   (digit_l_lit)
    );

    pong_score_glyph #(.CELL_X(DIGIT_R_X)) u_digit_r (
        .pos   (pos),
        .digit (scores.right),
        .lit   (digit_r_lit)
    );

    // Paddles, then ball, then digits, all the same white
    assign overlay_hit = paddle_l_hit || paddle_r_hit || ball_hit ||
                         digit_l_lit  || digit_r_lit;

    // Dashes 32 lines long
    assign mid_line_hit = (pos.h == MID_LINE_H) && (pos.v[5] == 1'b0);

    // ================================================
    // Colour select
    // ================================================
    always_comb begin
        dimmed.r = pixel_in.r >> 1;                 // Half intensity background
        dimmed.g = pixel_in.g >> 1;
        dimmed.b = pixel_in.b >> 1;

        if (!sync.active)     pixel_out = '0;      // Black in blanking
        else if (overlay_hit) pixel_out = OVERLAY_COLOR;
        else if (mid_line_hit) pixel_out = OVERLAY_COLOR;
        else                  pixel_out = dimmed;
    end

endmodule

`default_nettype wire

//--- src/vga_pong_top.sv
`default_nettype none

module vga_pong_top #(
    parameter int unsigned START_DELAY_CYCLES = 250_000_000,   // Shortened in simulation
    parameter int unsigned BALL_STEP_CYCLES   = 131_072
) (
    input  wire                          iCLK,
    input  wire                          iRST_N,
    input  wire pong_pkg::color_t        pixel_in,    // Source colour for pos
    output logic                         request,     // Pixel wanted this cycle
    output vga_timing_pkg::raster_pos_t  pos,
    output vga_timing_pkg::vga_sync_t    sync,
    output pong_pkg::color_t             pixel_out
);

    import pong_pkg::*;

    ball_state_t ball;                              // Ball engine to mixer
    score_pair_t scores;

    // ================================================
    // Raster, game state and picture
    // ================================================
    vga_raster_timer u_timer (
        .iCLK    (iCLK),
        .iRST_N  (iRST_N),
        .pos     (pos),
        .sync    (sync),
        .request (request)
    );

    pong_ball_engine #(
        .START_DELAY_CYCLES (START_DELAY_CYCLES),
        .BALL_STEP_CYCLES   (BALL_STEP_CYCLES)
    ) u_ball (
        .iCLK   (iCLK),
        .iRST_N (iRST_N),
        .ball   (ball),
        .scores (scores)
    );

    // Pure combinational overlay on the registered position
    pong_pixel_mixer u_mixer (
        .pos       (pos),
        .sync      (sync),
        .ball      (ball),
        .scores    (scores),
        .pixel_in  (pixel_in),
        .pixel_out (pixel_out)
    );

endmodule

`default_nettype wire

//--- verif/vga_pong_checker.sv
`default_nettype none

module vga_pong_checker (
    input  wire                              iCLK,
    input  wire                              iRST_N,
    input  wire vga_timing_pkg::raster_pos_t pos,
    input  wire vga_timing_pkg::vga_sync_t   sync,
    input  wire                              request
);

    timeunit 1ns;
    timeprecision 100ps;

    import vga_timing_pkg::*;

    int unsigned assert_errs = 0;                   // Read by the testbench at the end

    // ================================================
    // Raster timer properties
    // ================================================
    // Counter never leaves the line
    h_in_range: assert property (@(posedge iCLK) disable iff (!iRST_N)
        pos.h < hcount_t'(H_TOTAL))
        else begin
            assert_errs++;
            $error("h count %0d reached the line length", pos.h);
        end

    // Line count holds unless h is on its last count
    v_only_on_wrap: assert property (@(posedge iCLK) disable iff (!iRST_N)
        (pos.h != hcount_t'(H_TOTAL - 1)) |=> $stable(pos.v))
        else begin
            assert_errs++;
            $error("v count moved in the middle of a line");
        end

    // Request leads the picture by one line at the top, active elsewhere
    req_in_picture: assert property (@(posedge iCLK) disable iff (!iRST_N)
        request |-> (sync.active || pos.v == vcount_t'(V_BLANK_END - 1)))
        else begin
            assert_errs++;
            $error("request high outside the picture at h %0d v %0d", pos.h, pos.v);
        end

    hsync_window: assert property (@(posedge iCLK) disable iff (!iRST_N)
        sync.hsync_n == !((pos.h >= H_SYNC_FIRST) && (pos.h <= H_SYNC_LAST)))
        else begin
            assert_errs++;
            $error("hsync_n wrong at h %0d", pos.h);
        end

endmodule

bind vga_raster_timer vga_pong_checker u_checker (
    .iCLK    (iCLK),
    .iRST_N  (iRST_N),
    .pos     (pos),
    .sync    (sync),
    .request (request)
);

`default_nettype wire

//--- verif/vga_pong_tb.sv
`default_nettype none

module vga_pong_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import vga_timing_pkg::*;
    import pong_pkg::*;

    localparam int unsigned START_DELAY  = 100;     // Short start delay for simulation
    localparam int unsigned STEP_CYCLES  = 16;
    localparam int unsigned RUN_FRAMES   = 4;
    localparam int unsigned FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int unsigned CYCLE_LIMIT  = START_DELAY + RUN_FRAMES * FRAME_CYCLES + 1000;

    logic        iCLK;
    logic        iRST_N;
    color_t      pixel_in;
    logic        request;
    raster_pos_t pos;
    vga_sync_t   sync;
    color_t      pixel_out;

    raster_pos_t m_pos;                             // Model raster position
    ball_state_t m_ball;
    score_pair_t m_scores;
    int unsigned m_ticks;                           // Rising edges since reset release
    int unsigned pos_errs    = 0;
    int unsigned sync_errs   = 0;
    int unsigned req_errs    = 0;
    int unsigned pix_errs    = 0;
    int unsigned frames_seen = 0;
    int unsigned cycle_cnt   = 0;

    vga_pong_top #(
        .START_DELAY_CYCLES (START_DELAY),
        .BALL_STEP_CYCLES   (STEP_CYCLES)
    ) vga_pong_i (
        .iCLK      (iCLK),
        .iRST_N    (iRST_N),
        .pixel_in  (pixel_in),
        .request   (request),
        .pos       (pos),
        .sync      (sync),
        .pixel_out (pixel_out)
    );

    initial iCLK = 1'b0;
    always #4 iCLK = ~iCLK;                         // 8 ns period

    // ================================================
    // Model of the picture rules
    // ================================================
    function automatic logic glyph_lit(raster_pos_t p, int cell_x, score_t d);
        logic [6:0] segs;                           // Seven segment gfedcba
        int         h;
        int         v;
        logic       upper;
        logic       lower;
        case (d)
            4'd0:    segs = 7'h3F;
            4'd1:    segs = 7'h06;                  // b and c, right column
            4'd2:    segs = 7'h5B;
            4'd3:    segs = 7'h4F;
            4'd4:    segs = 7'h66;
            4'd5:    segs = 7'h6D;
            4'd6:    segs = 7'h7D;
            4'd7:    segs = 7'h07;
            4'd8:    segs = 7'h7F;
            4'd9:    segs = 7'h6F;
            default: segs = 7'h00;                  // Saturated score is blank
        endcase
        h = p.h;
        v = p.v;
        upper = (v >= DIGIT_TOP) && (v < DIGIT_MID);
        lower = (v >= DIGIT_MID) && (v < DIGIT_BOT);
        return ((h >= cell_x) && (h <= cell_x + DIGIT_W - 1) &&
                ((segs[0] && v == DIGIT_TOP) || (segs[6] && v == DIGIT_MID) ||
                 (segs[3] && v == DIGIT_BOT))) ||
               ((h == cell_x) && ((segs[5] && upper) || (segs[4] && lower))) ||
               ((h == cell_x + DIGIT_W) && ((segs[1] && upper) || (segs[2] && lower)));
    endfunction

    function automatic color_t expected_pixel(raster_pos_t p, ball_state_t b, score_pair_t s,
                                              color_t c, output string region);
        int     h;
        int     v;
        color_t px;
        h = p.h;
        v = p.v;
        px = '{r: c.r >> 1, g: c.g >> 1, b: c.b >> 1};
        region = "background";
        if (!((h >= H_BLANK_END) && (v >= V_BLANK_END))) begin
            region = "blank";
            px = '0;
        end else if ((v >= PADDLE_Y) && (v < PADDLE_Y + PADDLE_H) &&
                     (((h >= PADDLE_L_X) && (h < PADDLE_L_X + PADDLE_W)) ||
                      ((h >= PADDLE_R_X) && (h < PADDLE_R_X + PADDLE_W)))) begin
            region = "paddle";
            px = OVERLAY_COLOR;
        end else if ((h >= int'(b.x)) && (h < int'(b.x) + BALL_SIZE) &&
                     (v >= int'(b.y)) && (v < int'(b.y) + BALL_SIZE)) begin
            region = "ball";
            px = OVERLAY_COLOR;
        end else if (glyph_lit(p, DIGIT_L_X, s.left) || glyph_lit(p, DIGIT_R_X, s.right)) begin
            region = "score_digit";
            px = OVERLAY_COLOR;
        end else if ((h == MID_LINE_H) && ((v % 64) < 32)) begin
            region = "mid_line";                    // 32 lines on, 32 off
            px = OVERLAY_COLOR;
        end
        return px;
    endfunction

    function automatic vga_sync_t expected_sync(raster_pos_t p);
        vga_sync_t s;
        s.hsync_n = !((p.h >= H_SYNC_FIRST) && (p.h <= H_SYNC_LAST));
        s.vsync_n = !((p.v >= V_SYNC_FIRST) && (p.v <= V_SYNC_LAST));
        s.active  = (p.h >= H_BLANK_END) && (p.v >= V_BLANK_END);
        return s;
    endfunction

    function automatic logic expected_request(raster_pos_t p);
        return (p.h >= REQ_H_FIRST) && (p.h <= REQ_H_LAST) &&
               (p.v >= REQ_V_FIRST) && (p.v <= REQ_V_LAST);
    endfunction

    // Model state follows the DUT registers edge by edge
    always @(posedge iCLK or negedge iRST_N) begin
        ball_state_t nb;
        score_pair_t ns;
        if (!iRST_N) begin
            m_pos    <= '0;
            m_ball   <= '{x: BALL_X0, y: BALL_Y0, dir_right: 1'b1, dir_down: 1'b1};
            m_scores <= '0;
            m_ticks  <= 0;
        end else begin
            m_ticks <= m_ticks + 1;
            m_pos.h <= (m_pos.h == H_TOTAL - 1) ? '0 : m_pos.h + 1'b1;
            if (m_pos.h == H_TOTAL - 1) begin
                m_pos.v <= (m_pos.v == V_TOTAL - 1) ? '0 : m_pos.v + 1'b1;
            end
            // Step edges: first one right after the delay, then every STEP_CYCLES
            if ((m_ticks >= START_DELAY + 1) &&
                (((m_ticks - (START_DELAY + 1)) % STEP_CYCLES) == 0)) begin
                nb = m_ball;
                ns = m_scores;
                if (m_ball.dir_right && (int'(m_ball.x) + BALL_SIZE >= BALL_X_EDGE)) begin
                    nb.dir_right = 1'b0;
                    ns.left = (ns.left == SCORE_MAX) ? ns.left : ns.left + 1'b1;
                end else if (!m_ball.dir_right && (int'(m_ball.x) <= BALL_X_MIN)) begin
                    nb.dir_right = 1'b1;
                    ns.right = (ns.right == SCORE_MAX) ? ns.right : ns.right + 1'b1;
                end else begin
                    nb.x = m_ball.dir_right ? m_ball.x + 1'b1 : m_ball.x - 1'b1;
                end
                if (m_ball.dir_down && (int'(m_ball.y) + BALL_SIZE >= BALL_Y_EDGE)) begin
                    nb.dir_down = 1'b0;
                end else if (!m_ball.dir_down && (int'(m_ball.y) <= BALL_Y_MIN)) begin
                    nb.dir_down = 1'b1;
                end else begin
                    nb.y = m_ball.dir_down ? m_ball.y + 1'b1 : m_ball.y - 1'b1;
                end
                m_ball   <= nb;
                m_scores <= ns;
            end
        end
    end

    // ================================================
    // Compare tasks
    // ================================================
    task automatic check_pos(string name, raster_pos_t exp, raster_pos_t act);
        if (act !== exp) begin
            pos_errs++;
            $display("FAILED %s at %0t: expected h=%0d v=%0d, actual h=%0d v=%0d",
                     name, $time, exp.h, exp.v, act.h, act.v);
        end
    endtask

    task automatic check_sync(string name, vga_sync_t exp, vga_sync_t act);
        if (act !== exp) begin
            sync_errs++;
            $display("FAILED %s at %0t: expected %b, actual %b", name, $time, exp, act);
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            req_errs++;
            $display("FAILED %s at %0t: expected %b, actual %b", name, $time, exp, act);
        end
    endtask

    task automatic check_color(string name, color_t exp, color_t act);
        if (act !== exp) begin
            pix_errs++;
            $display("FAILED %s at %0t: expected %06h, actual %06h", name, $time, exp, act);
        end
    endtask

    // Outputs are settled mid cycle
    always @(negedge iCLK) begin
        string  region;
        color_t exp_pix;
        exp_pix = expected_pixel(m_pos, m_ball, m_scores, pixel_in, region);
        check_pos("raster_pos", m_pos, pos);
        check_sync("sync_blank", expected_sync(m_pos), sync);
        check_bit("request", expected_request(m_pos), request);
        check_color(region, exp_pix, pixel_out);
        if (iRST_N && (pos.h == H_TOTAL - 1) && (pos.v == V_TOTAL - 1)) begin
            frames_seen++;                          // Last pixel of a frame
        end
    end

    // ================================================
    // Stimulus, timeout and verdict
    // ================================================
    initial begin
        pixel_in = color_t'(24'($urandom(32'h1c35)));  // Seed once, first colour
        forever begin
            @(posedge iCLK);
            #1;
            pixel_in = color_t'(24'($urandom));     // Fresh source colour each cycle
        end
    end

    always @(posedge iCLK) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, only %0d of %0d frames completed",
                     cycle_cnt, frames_seen, RUN_FRAMES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        int unsigned assert_errs;
        iRST_N = 1'b0;
        repeat (4) @(posedge iCLK);
        #1;
        iRST_N = 1'b1;
        wait (frames_seen == RUN_FRAMES);
        @(posedge iCLK);
        assert_errs = vga_pong_i.u_timer.u_checker.assert_errs;
        $display("Error counts: raster_pos %0d, sync %0d, request %0d, pixel %0d, assertions %0d",
                 pos_errs, sync_errs, req_errs, pix_errs, assert_errs);
        if (pos_errs + sync_errs + req_errs + pix_errs + assert_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vga_pong.f
src/vga_timing_pkg.sv
src/pong_pkg.sv
src/vga_raster_timer.sv
src/pong_ball_engine.sv
src/pong_score_glyph.sv
src/pong_pixel_mixer.sv
src/vga_pong_top.sv
verif/vga_pong_checker.sv
verif/vga_pong_tb.sv

//--- Bender.yml
package:
  name: vga_pong

sources:
  # Packages first, then the design from the leaves up
  - src/vga_timing_pkg.sv
  - src/pong_pkg.sv
  - src/vga_raster_timer.sv
  - src/pong_ball_engine.sv
  - src/pong_score_glyph.sv
  - src/pong_pixel_mixer.sv
  - src/vga_pong_top.sv

  # Testbench, top module vga_pong_tb
  - target: test
    files:
      - verif/vga_pong_checker.sv
      - verif/vga_pong_tb.sv
